// ==== led_panel.f ====
led_panel_pkg.sv
pixel_write_port.sv
frame_buffer.sv
bcm_timer.sv
scan_sequencer.sv
row_fetch.sv
hub75_driver.sv
led_panel.sv
tb_led_panel.sv

// ==== Makefile ====
TOP = tb_led_panel

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f led_panel.f --top-module $(TOP)

sim:
	verilator --binary --timing --timescale 1ns/1ps -f led_panel.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_led_panel.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_led_panel;
  import led_panel_pkg::*;

  localparam logic [31:0] SEED = 32'h939ea4c9;
  localparam int TABLE_LEN      = 12;
  localparam int FIRST_PART     = 8;  // Rows after this one clear overlays.
  localparam int CREDIT_TIMEOUT = 400;
  localparam int ROW_TIMEOUT    = 4 * BASE_TIME + 4 * COLS;
  localparam int FRAME_TIMEOUT  = 4000;

  logic       clk;
  logic       rst_n;
  logic       wr_valid;
  pixel_wr_t  wr_cmd;
  logic       credit;
  logic [2:0] rgb0;
  logic [2:0] rgb1;
  logic       pclk;
  pair_t      row_addr;
  logic       latch;
  logic       oe_n;

  pixel_t      img_model [ROWS][COLS];
  overlay_t    ovl_model [ROWS][COLS];
  pixel_wr_t   write_table [TABLE_LEN];
  logic [31:0] rng_state;
  int          credits;
  logic        prev_pclk;
  logic        prev_latch;

  led_panel led_panel_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .wr_valid(wr_valid),
      .wr_cmd  (wr_cmd),
      .credit  (credit),
      .rgb0    (rgb0),
      .rgb1    (rgb1),
      .pclk    (pclk),
      .row_addr(row_addr),
      .latch   (latch),
      .oe_n    (oe_n)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped after the first failure.");
  endtask

  task automatic check_value(input string test, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("ERROR %s: expected 0x%0h, actual 0x%0h", test, expected, actual));
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic pixel_wr_t make_write(input row_t row, input col_t col, input logic layer,
                                           input logic en, input pixel_t color);
    pixel_wr_t w;
    w.row         = row;
    w.col         = col;
    w.layer       = layer;
    w.value.en    = en;
    w.value.color = color;
    return w;
  endfunction

  // Bit p of red, green and blue of whatever the panel should show at this pixel.
  function automatic logic [2:0] expected_bits(input row_t row, input col_t col,
                                               input plane_t plane);
    logic [5:0] shown;
    shown = ovl_model[row][col].en ? ovl_model[row][col].color : img_model[row][col];
    shown = shown >> plane;
    return {shown[4], shown[2], shown[0]};
  endfunction

  // Advances to the next falling edge and counts returned credits.
  task automatic next_cycle();
    prev_pclk  = pclk;
    prev_latch = latch;
    @(negedge clk);
    if (credit) begin
      credits++;
      check_value("credit count bound", 32'd1, 32'(credits <= WR_CREDITS));
    end
  endtask

  task automatic check_idle_outputs(input string name);
    check_value({name, " oe_n"}, 32'd1, 32'(oe_n));
    check_value({name, " latch"}, 32'd0, 32'(latch));
    check_value({name, " pclk"}, 32'd0, 32'(pclk));
    check_value({name, " credit"}, 32'd0, 32'(credit));
  endtask

  task automatic wait_first_pclk();
    int waited;
    waited = 0;
    next_cycle();
    while (!pclk) begin
      check_idle_outputs("after reset");
      waited++;
      if (waited > 8) abort_run("The panel clock did not start after reset.");
      next_cycle();
    end
  endtask

  task automatic send_write(input pixel_wr_t cmd);
    int waited;
    waited = 0;
    while (credits == 0) begin
      next_cycle();
      waited++;
      if (waited > CREDIT_TIMEOUT) abort_run("No write credit came back in time.");
    end
    wr_valid = 1'b1;
    wr_cmd   = cmd;
    credits--;
    if (cmd.layer) ovl_model[cmd.row][cmd.col] = cmd.value;
    else img_model[cmd.row][cmd.col] = cmd.value.color;
    next_cycle();
    wr_valid = 1'b0;
  endtask

  task automatic wait_credits_returned();
    int waited;
    waited = 0;
    while (credits != WR_CREDITS) begin
      next_cycle();
      waited++;
      if (waited > CREDIT_TIMEOUT) abort_run("Outstanding write credits never came back.");
    end
  endtask

  task automatic check_credit_burst();
    int i;
    for (i = 0; i < WR_CREDITS; i++) begin
      rng_state = xorshift32(rng_state);
      send_write(make_write(4'd0, col_t'(i), 1'b0, 1'b0, pixel_t'(rng_state[5:0])));
    end
    wait_credits_returned();
    repeat (2 * (2 * COLS + 2 * BASE_TIME)) next_cycle();  // Any extra credit shows up here.
  endtask

  task automatic fill_layers();
    int layer;
    int r;
    int c;
    for (layer = 0; layer < 2; layer++) begin
      for (r = 0; r < ROWS; r++) begin
        for (c = 0; c < COLS; c++) begin
          rng_state = xorshift32(rng_state);
          send_write(make_write(row_t'(r), col_t'(c), layer[0], rng_state[6],
                                pixel_t'(rng_state[5:0])));
        end
      end
    end
    wait_credits_returned();
  endtask

  // Columns: row, column, layer, overlay enable, colour as RR_GG_BB.
  task automatic load_table();
    write_table[0]  = make_write(4'd0, 4'd0, 1'b0, 1'b0, 6'b11_11_11);
    write_table[1]  = make_write(4'd0, 4'd0, 1'b1, 1'b1, 6'b10_00_01);
    write_table[2]  = make_write(4'd8, 4'd0, 1'b0, 1'b0, 6'b01_10_11);
    write_table[3]  = make_write(4'd8, 4'd0, 1'b1, 1'b1, 6'b00_11_00);
    write_table[4]  = make_write(4'd7, 4'd15, 1'b0, 1'b0, 6'b10_10_10);
    write_table[5]  = make_write(4'd7, 4'd15, 1'b1, 1'b1, 6'b01_01_01);
    write_table[6]  = make_write(4'd15, 4'd15, 1'b1, 1'b1, 6'b11_00_11);
    write_table[7]  = make_write(4'd3, 4'd9, 1'b0, 1'b0, 6'b00_01_10);
    write_table[8]  = make_write(4'd0, 4'd0, 1'b1, 1'b0, 6'b11_11_11);
    write_table[9]  = make_write(4'd8, 4'd0, 1'b1, 1'b0, 6'b00_00_00);
    write_table[10] = make_write(4'd7, 4'd15, 1'b1, 1'b0, 6'b11_11_11);
    write_table[11] = make_write(4'd15, 4'd15, 1'b1, 1'b0, 6'b01_01_01);
  endtask

  task automatic apply_table(input int first, input int last);
    int i;
    for (i = first; i < last; i++) send_write(write_table[i]);
    wait_credits_returned();
  endtask

  task automatic check_frame(input string name);
    int     waited;
    int     row_i;
    int     pulses;
    int     low_len;
    pair_t  last_addr;
    logic   found;
    logic   latched;
    row_t   top_row;
    col_t   col;
    plane_t plane;

    // The second latch with the top address closes a frame.
    waited    = 0;
    last_addr = '0;
    found     = 1'b0;
    while (!found) begin
      next_cycle();
      waited++;
      if (waited > FRAME_TIMEOUT) abort_run("The last latch of a frame never came.");
      if (latch && !prev_latch) begin
        found = (row_addr == pair_t'(ROW_PAIRS - 1)) && (last_addr == pair_t'(ROW_PAIRS - 1));
        last_addr = row_addr;
      end
    end

    for (row_i = 0; row_i < 2 * ROW_PAIRS; row_i++) begin
      top_row = row_t'(row_i / 2);
      plane   = plane_t'(row_i % 2);
      pulses  = 0;
      waited  = 0;
      latched = 1'b0;
      while (!latched) begin
        next_cycle();
        waited++;
        if (waited > ROW_TIMEOUT) abort_run("No latch followed the shifting of a row.");
        if (pclk && !prev_pclk) begin
          if (pulses < COLS) begin
            col = col_t'(COLS - 1 - pulses);  // The far column goes out first.
            check_value($sformatf("%s pair %0d plane %0d col %0d upper", name, top_row,
                                  plane, col),
                        32'(expected_bits(top_row, col, plane)), 32'(rgb0));
            check_value($sformatf("%s pair %0d plane %0d col %0d lower", name, top_row,
                                  plane, col),
                        32'(expected_bits(top_row + row_t'(ROW_PAIRS), col, plane)),
                        32'(rgb1));
            check_value({name, " oe_n during shift"}, 32'd1, 32'(oe_n));
          end
          pulses++;
        end
        latched = latch && !prev_latch;
      end
      check_value($sformatf("%s latch address of row %0d", name, row_i), 32'(top_row),
                  32'(row_addr));
      check_value($sformatf("%s pclk count of row %0d", name, row_i), COLS, pulses);

      waited = 0;
      while (oe_n) begin
        next_cycle();
        waited++;
        if (waited > ROW_TIMEOUT) abort_run("The output enable never went active after a latch.");
      end
      low_len = 0;
      while (!oe_n) begin
        low_len++;
        next_cycle();
        if (low_len > ROW_TIMEOUT) abort_run("The output enable stayed active far too long.");
      end
      check_value($sformatf("%s show length of row %0d", name, row_i), BASE_TIME << plane,
                  low_len);
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    wr_valid   = 1'b0;
    wr_cmd     = '0;
    credits    = WR_CREDITS;
    rng_state  = SEED;
    prev_pclk  = 1'b0;
    prev_latch = 1'b0;
    load_table();
    repeat (8) begin
      next_cycle();
      check_idle_outputs("reset");
    end
    rst_n = 1'b1;
    wait_first_pclk();
    check_credit_burst();
    fill_layers();
    apply_table(0, FIRST_PART);
    check_frame("overlay frame");
    apply_table(FIRST_PART, TABLE_LEN);  // Cleared overlays must reveal the image.
    check_frame("cleared frame");
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== led_panel.sv ====
`timescale 1ns/1ps
`default_nettype none

module led_panel (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      wr_valid,
  input  led_panel_pkg::pixel_wr_t  wr_cmd,
  output logic                      credit,
  output logic [2:0]                rgb0,
  output logic [2:0]                rgb1,
  output logic                      pclk,
  output led_panel_pkg::pair_t      row_addr,
  output logic                      latch,
  output logic                      oe_n
);
  import led_panel_pkg::*;

  logic      img_we;
  logic      ovl_we;
  row_t      wr_row;
  col_t      wr_col;
  overlay_t  wr_data;
  row_t      rd_row0;
  row_t      rd_row1;
  col_t      rd_col;
  pixel_t    img0;
  pixel_t    img1;
  overlay_t  ovl0;
  overlay_t  ovl1;
  logic      timer_start;
  logic      timer_mode_shift;
  logic      timer_done;
  col_t      timer_col;
  scan_ctl_t scan;
  rgb_pair_t bits;

  pixel_write_port u_write_port (
      .clk       (clk),
      .rst_n     (rst_n),
      .wr_valid  (wr_valid),
      .wr_cmd    (wr_cmd),
      .scan_shift(scan.shift),
      .img_we    (img_we),
      .ovl_we    (ovl_we),
      .wr_row    (wr_row),
      .wr_col    (wr_col),
      .wr_data   (wr_data),
      .credit    (credit)
  );

  // The image layer keeps only the colour of a write.
  frame_buffer #(
      .payload_t(pixel_t)
  ) u_image_fb (
      .clk     (clk),
      .we      (img_we),
      .wr_row  (wr_row),
      .wr_col  (wr_col),
      .wr_data (wr_data.color),
      .rd_row0 (rd_row0),
      .rd_row1 (rd_row1),
      .rd_col  (rd_col),
      .rd_data0(img0),
      .rd_data1(img1)
  );

  frame_buffer #(
      .payload_t(overlay_t)
  ) u_overlay_fb (
      .clk     (clk),
      .we      (ovl_we),
      .wr_row  (wr_row),
      .wr_col  (wr_col),
      .wr_data (wr_data),
      .rd_row0 (rd_row0),
      .rd_row1 (rd_row1),
      .rd_col  (rd_col),
      .rd_data0(ovl0),
      .rd_data1(ovl1)
  );

  bcm_timer u_timer (
      .clk       (clk),
      .rst_n     (rst_n),
      .start     (timer_start),
      .mode_shift(timer_mode_shift),
      .plane     (scan.plane),
      .col       (timer_col),
      .done      (timer_done)
  );

  scan_sequencer u_sequencer (
      .clk             (clk),
      .rst_n           (rst_n),
      .timer_done      (timer_done),
      .timer_col       (timer_col),
      .timer_start     (timer_start),
      .timer_mode_shift(timer_mode_shift),
      .scan            (scan)
  );

  row_fetch u_fetch (
      .scan   (scan),
      .img0   (img0),
      .img1   (img1),
      .ovl0   (ovl0),
      .ovl1   (ovl1),
      .rd_row0(rd_row0),
      .rd_row1(rd_row1),
      .rd_col (rd_col),
      .bits   (bits)
  );

  hub75_driver u_driver (
      .clk     (clk),
      .rst_n   (rst_n),
      .scan    (scan),
      .bits    (bits),
      .rgb0    (rgb0),
      .rgb1    (rgb1),
      .pclk    (pclk),
      .row_addr(row_addr),
      .latch   (latch),
      .oe_n    (oe_n)
  );

endmodule

`default_nettype wire

// ==== hub75_driver.sv ====
`timescale 1ns/1ps
`default_nettype none

module hub75_driver (
  input  logic                      clk,
  input  logic                      rst_n,
  input  led_panel_pkg::scan_ctl_t  scan,
  input  led_panel_pkg::rgb_pair_t  bits,
  output logic [2:0]                rgb0,
  output logic [2:0]                rgb1,
  output logic                      pclk,
  output led_panel_pkg::pair_t      row_addr,
  output logic                      latch,
  output logic                      oe_n
);
  logic phase;  // Low in the data cycle of a column, high in its clock cycle.

  always_ff @(posedge clk) begin
    if (scan.shift && !phase) begin
      rgb0 <= bits.rgb0;
      rgb1 <= bits.rgb1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase    <= 1'b0;
      pclk     <= 1'b0;
      latch    <= 1'b0;
      row_addr <= '0;
      oe_n     <= 1'b1;
    end else begin
      phase <= scan.shift && !phase;
      pclk  <= scan.shift && phase;  // Rises one cycle after the data settles.
      latch <= scan.latch;
      if (scan.latch) row_addr <= scan.pair;
      oe_n <= !scan.show;
    end
  end

endmodule

`default_nettype wire

// ==== row_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module row_fetch (
  input  led_panel_pkg::scan_ctl_t  scan,
  input  led_panel_pkg::pixel_t     img0,
  input  led_panel_pkg::pixel_t     img1,
  input  led_panel_pkg::overlay_t   ovl0,
  input  led_panel_pkg::overlay_t   ovl1,
  output led_panel_pkg::row_t       rd_row0,
  output led_panel_pkg::row_t       rd_row1,
  output led_panel_pkg::col_t       rd_col,
  output led_panel_pkg::rgb_pair_t  bits
);
  import led_panel_pkg::*;

  // An enabled overlay pixel hides the image pixel below it.
  function automatic logic [2:0] fuse_bits(
    input overlay_t ovl,
    input pixel_t   img,
    input plane_t   plane
  );
    pixel_t px;
    px = ovl.en ? ovl.color : img;
    return {px.red[plane], px.green[plane], px.blue[plane]};
  endfunction

  // The lower half of the panel sits ROW_PAIRS rows below the upper half.
  assign rd_row0 = row_t'(scan.pair);
  assign rd_row1 = row_t'(scan.pair) + row_t'(ROW_PAIRS);
  assign rd_col  = scan.col;

  always_comb begin
    bits.rgb0 = fuse_bits(ovl0, img0, scan.plane);
    bits.rgb1 = fuse_bits(ovl1, img1, scan.plane);
  end

endmodule

`default_nettype wire

// ==== scan_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module scan_sequencer (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      timer_done,
  input  led_panel_pkg::col_t       timer_col,
  output logic                      timer_start,
  output logic                      timer_mode_shift,
  output led_panel_pkg::scan_ctl_t  scan
);
  import led_panel_pkg::*;

  typedef enum logic [1:0] {
    SHIFT,
    LATCH,
    SHOW,
    NEXT
  } state_t;

  state_t state;
  pair_t  pair;
  plane_t plane;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= SHIFT;
      pair  <= '0;
      plane <= '0;
    end else begin
      case (state)
        SHIFT: begin
          if (timer_done) state <= LATCH;
        end
        LATCH: begin
          state <= SHOW;
        end
        SHOW: begin
          if (timer_done) state <= NEXT;
        end
        NEXT: begin
          state <= SHIFT;
          if (plane == plane_t'(PLANES - 1)) begin
            plane <= '0;
            pair  <= (pair == pair_t'(ROW_PAIRS - 1)) ? '0 : pair + 1'b1;
          end else begin
            plane <= plane + 1'b1;
          end
        end
        default: begin
          state <= SHIFT;
        end
      endcase
    end
  end

  // The timer is loaded on the transition, so its count is ready in the first cycle.
  assign timer_start      = (state == LATCH) || (state == NEXT);
  assign timer_mode_shift = (state == NEXT);

  always_comb begin
    scan.shift = (state == SHIFT);
    scan.col   = timer_col;
    scan.pair  = pair;
    scan.plane = plane;
    scan.latch = (state == LATCH);
    scan.show  = (state == SHOW);
  end

endmodule

`default_nettype wire

// ==== bcm_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module bcm_timer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   start,
  input  logic                   mode_shift,
  input  led_panel_pkg::plane_t  plane,
  output led_panel_pkg::col_t    col,
  output logic                   done
);
  import led_panel_pkg::*;

  typedef logic [$clog2(BASE_TIME << (PLANES - 1)) - 1:0] cnt_t;

  cnt_t cnt;    // Cycles left minus one.
  logic active;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt    <= cnt_t'(2 * COLS - 1);  // The first shift begins right after reset.
      active <= 1'b1;
    end else if (start) begin
      cnt    <= mode_shift ? cnt_t'(2 * COLS - 1) : cnt_t'((BASE_TIME << plane) - 1);
      active <= 1'b1;
    end else if (active) begin
      if (cnt == '0) active <= 1'b0;
      else cnt <= cnt - 1'b1;
    end
  end

  assign done = active && (cnt == '0);

  // Counting down sends the far column first, as it travels furthest along the chain.
  assign col = col_t'(cnt >> 1);

endmodule

`default_nettype wire

// ==== frame_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_buffer #(
  parameter type payload_t = led_panel_pkg::pixel_t
) (
  input  logic                 clk,
  input  logic                 we,
  input  led_panel_pkg::row_t  wr_row,
  input  led_panel_pkg::col_t  wr_col,
  input  payload_t             wr_data,
  input  led_panel_pkg::row_t  rd_row0,
  input  led_panel_pkg::row_t  rd_row1,
  input  led_panel_pkg::col_t  rd_col,
  output payload_t             rd_data0,
  output payload_t             rd_data1
);
  import led_panel_pkg::*;

  payload_t mem [ROWS][COLS];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_row][wr_col] <= wr_data;
    end
  end

  // Both halves of the panel are read in the same cycle.
  assign rd_data0 = mem[rd_row0][rd_col];
  assign rd_data1 = mem[rd_row1][rd_col];

endmodule

`default_nettype wire

// ==== pixel_write_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_write_port (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      wr_valid,
  input  led_panel_pkg::pixel_wr_t  wr_cmd,
  input  logic                      scan_shift,
  output logic                      img_we,
  output logic                      ovl_we,
  output led_panel_pkg::row_t       wr_row,
  output led_panel_pkg::col_t       wr_col,
  output led_panel_pkg::overlay_t   wr_data,
  output logic                      credit
);
  import led_panel_pkg::*;

  typedef logic [$clog2(WR_CREDITS) - 1:0] ptr_t;

  pixel_wr_t                            fifo_mem [WR_CREDITS];
  ptr_t                                 wr_ptr;
  ptr_t                                 rd_ptr;
  logic [$clog2(WR_CREDITS + 1) - 1:0]  count;
  logic                                 pop;
  pixel_wr_t                            head;

  // The host only writes while it holds a credit, so the queue cannot overflow.
  assign pop  = !scan_shift && (count != '0);
  assign head = fifo_mem[rd_ptr];

  assign img_we  = pop && !head.layer;
  assign ovl_we  = pop && head.layer;
  assign wr_row  = head.row;
  assign wr_col  = head.col;
  assign wr_data = head.value;

  always_ff @(posedge clk) begin
    if (wr_valid) fifo_mem[wr_ptr] <= wr_cmd;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (wr_valid) wr_ptr <= (wr_ptr == ptr_t'(WR_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == ptr_t'(WR_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
      if (wr_valid && !pop) count <= count + 1'b1;
      else if (pop && !wr_valid) count <= count - 1'b1;
      credit <= pop;  // One credit back the cycle after the buffer write.
    end
  end

endmodule

`default_nettype wire

// ==== led_panel_pkg.sv ====
`default_nettype none

package led_panel_pkg;

  localparam int COLS       = 16;
  localparam int ROWS       = 16;
  localparam int ROW_PAIRS  = 8;
  localparam int PLANES     = 2;
  localparam int BASE_TIME  = 32;  // Display cycles of plane 0.
  localparam int WR_CREDITS = 4;

  typedef logic [3:0] col_t;
  typedef logic [3:0] row_t;
  typedef logic [2:0] pair_t;
  typedef logic [0:0] plane_t;

  typedef struct packed {
    logic [1:0] red;
    logic [1:0] green;
    logic [1:0] blue;
  } pixel_t;

  typedef struct packed {
    logic   en;
    pixel_t color;
  } overlay_t;

  // Layer 0 writes the image buffer, layer 1 the overlay buffer.
  typedef struct packed {
    row_t     row;
    col_t     col;
    logic     layer;
    overlay_t value;
  } pixel_wr_t;

  // Bit 2 is red, bit 1 green, bit 0 blue.
  typedef struct packed {
    logic [2:0] rgb0;
    logic [2:0] rgb1;
  } rgb_pair_t;

  typedef struct packed {
    logic   shift;
    col_t   col;
    pair_t  pair;
    plane_t plane;
    logic   latch;
    logic   show;
  } scan_ctl_t;

endpackage

`default_nettype wire
